//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_pe_output_stage
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run ended without a result, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/flit_if.sv
`timescale 1ns/1ps

// flit channel between the packetizer and the output queue
interface flit_if import snn_noc_pkg::*; ();

    logic              valid;
    logic              ready;  // low while the queue is full
    logic [FLIT_W-1:0] flit;
    logic              is_ack; // marks the acknowledge flit that closes a location

    modport source (
        output valid,
        output flit,
        output is_ack,
        input  ready
    );

    modport sink (
        input  valid,
        input  flit,
        input  is_ack,
        output ready
    );

endinterface

//--- logic/membrane_accumulator.sv
`timescale 1ns/1ps

module membrane_accumulator import snn_noc_pkg::*; #(
    parameter int NUM_LOC   = 16,
    parameter int THRESHOLD = 64
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        psum_valid,
    input  logic signed [RESIDUE_W-1:0] psum,
    input  logic [CONV_LOC_W-1:0]       psum_loc,
    input  logic                        psum_last,     // closes the group of beats for psum_loc
    input  logic                        psum_timestep, // final timestep, residue is retired
    output logic                        psum_ready,
    neuron_result_if.source             result
);

    localparam int LOC_IDX_W = (NUM_LOC > 1) ? $clog2(NUM_LOC) : 1;
    localparam logic signed [RESIDUE_W-1:0] RES_MAX = {1'b0, {(RESIDUE_W-1){1'b1}}};
    localparam logic signed [RESIDUE_W-1:0] RES_MIN = {1'b1, {(RESIDUE_W-1){1'b0}}};
    localparam logic signed [RESIDUE_W-1:0] THRESH  = RESIDUE_W'(THRESHOLD);

    logic signed [RESIDUE_W-1:0] residue_mem [NUM_LOC]; // one stored residue per location
    logic signed [RESIDUE_W-1:0] run_sum;               // beats seen so far for the open location
    logic signed [RESIDUE_W-1:0] beat_sum;
    logic signed [RESIDUE_W-1:0] potential;
    logic signed [RESIDUE_W-1:0] new_residue;
    logic                        new_spike;
    logic [LOC_IDX_W-1:0]        loc_idx;
    logic                        beat_fire;

    logic                        res_valid;
    logic [CONV_LOC_W-1:0]       res_loc;
    logic signed [RESIDUE_W-1:0] res_residue;
    logic                        res_outspike;
    logic                        res_timestep;

    // signed add that clamps to the residue range instead of wrapping
    function automatic logic signed [RESIDUE_W-1:0] sat_add(
        input logic signed [RESIDUE_W-1:0] a,
        input logic signed [RESIDUE_W-1:0] b
    );
        logic signed [RESIDUE_W:0] wide;
        wide = {a[RESIDUE_W-1], a} + {b[RESIDUE_W-1], b};
        // the two top bits disagree only when the true sum left the range
        if (wide[RESIDUE_W] != wide[RESIDUE_W-1]) begin
            return wide[RESIDUE_W] ? RES_MIN : RES_MAX;
        end
        return wide[RESIDUE_W-1:0];
    endfunction

    assign loc_idx    = psum_loc[LOC_IDX_W-1:0];
    assign psum_ready = !res_valid;       // a pending result blocks the filter engine
    assign beat_fire  = psum_valid && psum_ready;

    assign beat_sum    = sat_add(run_sum, psum);                  // running sum including this beat
    assign potential   = sat_add(residue_mem[loc_idx], beat_sum); // only meaningful on the last beat
    assign new_spike   = (potential >= THRESH);
    assign new_residue = new_spike ? (potential - THRESH) : potential; // subtractive reset on a spike

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_sum   <= '0;
            res_valid <= 1'b0;
            for (int i = 0; i < NUM_LOC; i++) begin
                residue_mem[i] <= '0; // every neuron starts an inference at rest
            end
        end else begin
            if (result.valid && result.ready) begin
                res_valid <= 1'b0;
            end
            if (beat_fire) begin
                if (psum_last) begin
                    run_sum   <= '0;   // next group starts a new location
                    res_valid <= 1'b1;
                    // the final timestep retires the location so the next inference starts clean
                    residue_mem[loc_idx] <= psum_timestep ? '0 : new_residue;
                end else begin
                    run_sum <= beat_sum;
                end
            end
        end
    end

    // result fields are loaded with the last beat and held until the packetizer takes them
    always_ff @(posedge clk) begin
        if (beat_fire && psum_last) begin
            res_loc      <= psum_loc;
            res_residue  <= new_residue; // carried even when the memory entry is cleared
            res_outspike <= new_spike;
            res_timestep <= psum_timestep;
        end
    end

    assign result.valid    = res_valid;
    assign result.conv_loc = res_loc;
    assign result.residue  = res_residue;
    assign result.outspike = res_outspike;
    assign result.timestep = res_timestep;

    // a location beyond the memory would alias another neuron's residue
    a_loc_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        psum_valid |-> (psum_loc < NUM_LOC))
        else $error("psum_loc %0d outside %0d locations", psum_loc, NUM_LOC);

endmodule

//--- logic/neuron_result_if.sv
`timescale 1ns/1ps

// one finished neuron update travelling from the accumulator to the packetizer
interface neuron_result_if import snn_noc_pkg::*; ();

    logic                        valid;    // result registers hold a fresh update
    logic                        ready;    // packetizer can take it this cycle
    logic [CONV_LOC_W-1:0]       conv_loc;
    logic signed [RESIDUE_W-1:0] residue;  // residue left after the threshold test
    logic                        outspike;
    logic                        timestep; // high on the last timestep of the inference

    modport source (
        output valid,
        output conv_loc,
        output residue,
        output outspike,
        output timestep,
        input  ready
    );

    modport sink (
        input  valid,
        input  conv_loc,
        input  residue,
        input  outspike,
        input  timestep,
        output ready
    );

endinterface

//--- logic/noc_output_queue.sv
`timescale 1ns/1ps

module noc_output_queue import snn_noc_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    flit_if.sink              flit_in,
    input  logic              noc_ready, // router input buffer has room
    output logic              noc_valid,
    output logic [FLIT_W-1:0] noc_flit
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [FLIT_W-1:0] mem [QUEUE_DEPTH]; // flit storage, written in arrival order
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;             // entries currently held
    logic              full;
    logic              wr_en;
    logic              rd_en;
    logic              prev_final;        // last written flit was a final-timestep spike

    // pointers wrap at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full          = (count == CNT_W'(QUEUE_DEPTH));
    assign flit_in.ready = !full;
    assign wr_en         = flit_in.valid && flit_in.ready;
    assign rd_en         = noc_valid && noc_ready;

    assign noc_valid = (count != '0); // only registered state reaches the network port
    assign noc_flit  = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            prev_final <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr     <= ptr_inc(wr_ptr);
                prev_final <= !flit_in.is_ack && flit_in.flit[TSTEP_BIT];
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither leave the fill level alone
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= flit_in.flit;
        end
    end

    // a write into a full queue would overwrite the oldest unsent flit
    // full in pointer terms is both pointers on the same slot with entries still held
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !((wr_ptr == rd_ptr) && (count != '0)))
        else $error("flit written into a full output queue");

    // every final spike is followed directly by its ack, and an ack never comes alone
    a_ack_pairing: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (flit_in.is_ack == prev_final))
        else $error("ack flit out of sequence with the final spike flit");

endmodule

//--- logic/packetizer.sv
`timescale 1ns/1ps

module packetizer import snn_noc_pkg::*; #(
    parameter logic [NODE_W-1:0] PE_NODE       = '0,
    parameter logic [HOP_W-1:0]  X_HOP_OUT     = '0,
    parameter logic [HOP_W-1:0]  Y_HOP_OUT     = '0,
    parameter dir_t              DIRECTION_OUT = dir_east,
    parameter logic [HOP_W-1:0]  X_HOP_ACK     = '0,
    parameter logic [HOP_W-1:0]  Y_HOP_ACK     = '0,
    parameter dir_t              DIRECTION_ACK = dir_east
) (
    input  logic          clk,
    input  logic          rst_n,
    neuron_result_if.sink result,
    flit_if.source        flit_out
);

    pkt_state_t state;

    logic [CONV_LOC_W-1:0]       cap_loc;      // copy of the accepted result
    logic signed [RESIDUE_W-1:0] cap_residue;
    logic                        cap_spike;
    logic                        cap_ts;       // final timestep, an ack flit follows
    logic [FLIT_W-1:0]           spike_flit;
    logic [FLIT_W-1:0]           ack_flit;
    logic                        result_fire;
    logic                        flit_fire;

    assign result_fire = result.valid && result.ready;
    assign flit_fire   = flit_out.valid && flit_out.ready;

    // spike flit carries the neuron state along the outbound route
    always_comb begin
        spike_flit                               = '0;
        spike_flit[DIR_LO +: DIR_W]              = DIRECTION_OUT;
        spike_flit[XHOP_LO +: HOP_W]             = X_HOP_OUT;
        spike_flit[YHOP_LO +: HOP_W]             = Y_HOP_OUT;
        spike_flit[TSTEP_BIT]                    = cap_ts;
        spike_flit[SPIKE_BIT]                    = cap_spike;
        spike_flit[NODE_LO +: NODE_W]            = PE_NODE;
        spike_flit[RESIDUE_LO +: RESIDUE_W]      = cap_residue;
        spike_flit[CONV_LOC_LO +: CONV_LOC_W]    = cap_loc;
    end

    // ack flit goes back to the source node, only the header and the flag are set
    always_comb begin
        ack_flit                   = '0;
        ack_flit[DIR_LO +: DIR_W]  = DIRECTION_ACK;
        ack_flit[XHOP_LO +: HOP_W] = X_HOP_ACK;
        ack_flit[YHOP_LO +: HOP_W] = Y_HOP_ACK;
        ack_flit[ACK_BIT]          = 1'b1;
        ack_flit[NODE_LO +: NODE_W] = PE_NODE;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pkt_idle;
        end else begin
            case (state)
                pkt_idle:  if (result_fire) state <= pkt_spike;
                pkt_spike: if (flit_fire) state <= cap_ts ? pkt_ack : pkt_idle;
                pkt_ack:   if (flit_fire) state <= pkt_idle;
                default:   state <= pkt_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (result_fire) begin
            cap_loc     <= result.conv_loc;
            cap_residue <= result.residue;
            cap_spike   <= result.outspike;
            cap_ts      <= result.timestep;
        end
    end

    assign result.ready    = (state == pkt_idle); // one result in flight at a time
    assign flit_out.valid  = (state != pkt_idle);
    assign flit_out.is_ack = (state == pkt_ack);
    assign flit_out.flit   = (state == pkt_ack) ? ack_flit : spike_flit;

    // the queue may sample the flit on any later cycle, so it must not move while stalled
    a_flit_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (flit_out.valid && !flit_out.ready) |=> (flit_out.valid && $stable(flit_out.flit)))
        else $error("flit changed while stalled by the output queue");

endmodule

//--- logic/pe_output_stage.sv
`timescale 1ns/1ps

module pe_output_stage import snn_noc_pkg::*; #(
    parameter int                NUM_LOC       = 16,
    parameter int                THRESHOLD     = 64,
    parameter int                QUEUE_DEPTH   = 4,
    parameter logic [NODE_W-1:0] PE_NODE       = 4'd5,
    parameter logic [HOP_W-1:0]  X_HOP_OUT     = 3'd1,
    parameter logic [HOP_W-1:0]  Y_HOP_OUT     = 3'd0,
    parameter dir_t              DIRECTION_OUT = dir_east,
    parameter logic [HOP_W-1:0]  X_HOP_ACK     = 3'd2,
    parameter logic [HOP_W-1:0]  Y_HOP_ACK     = 3'd1,
    parameter dir_t              DIRECTION_ACK = dir_west
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // partial sums from the filter engine
    input  logic                        psum_valid,
    output logic                        psum_ready,
    input  logic signed [RESIDUE_W-1:0] psum,
    input  logic [CONV_LOC_W-1:0]       psum_loc,
    input  logic                        psum_last,
    input  logic                        psum_timestep,

    // injection port of the mesh router
    output logic                        noc_valid,
    input  logic                        noc_ready,
    output logic [FLIT_W-1:0]           noc_flit
);

    neuron_result_if result_ch (); // accumulator to packetizer
    flit_if          flit_ch ();   // packetizer to queue

    membrane_accumulator #(
        .NUM_LOC       (NUM_LOC),
        .THRESHOLD     (THRESHOLD)
    ) u_membrane_accumulator (
        .clk           (clk),
        .rst_n         (rst_n),
        .psum_valid    (psum_valid),
        .psum          (psum),
        .psum_loc      (psum_loc),
        .psum_last     (psum_last),
        .psum_timestep (psum_timestep),
        .psum_ready    (psum_ready),
        .result        (result_ch.source)
    );

    // the header of every flit is fixed per node
    packetizer #(
        .PE_NODE       (PE_NODE),
        .X_HOP_OUT     (X_HOP_OUT),
        .Y_HOP_OUT     (Y_HOP_OUT),
        .DIRECTION_OUT (DIRECTION_OUT),
        .X_HOP_ACK     (X_HOP_ACK),
        .Y_HOP_ACK     (Y_HOP_ACK),
        .DIRECTION_ACK (DIRECTION_ACK)
    ) u_packetizer (
        .clk           (clk),
        .rst_n         (rst_n),
        .result        (result_ch.sink),
        .flit_out      (flit_ch.source)
    );

    noc_output_queue #(
        .QUEUE_DEPTH   (QUEUE_DEPTH)
    ) u_noc_output_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .flit_in       (flit_ch.sink),
        .noc_ready     (noc_ready),
        .noc_valid     (noc_valid),
        .noc_flit      (noc_flit)
    );

endmodule

//--- logic/snn_noc_pkg.sv
package snn_noc_pkg;

    // a location index selects one output neuron of the convolution
    localparam int CONV_LOC_W = 10;
    localparam int RESIDUE_W  = 13; // membrane residue and partial sums share this signed width

    // widths of the routing header fields
    localparam int DIR_W  = 2;
    localparam int HOP_W  = 3;
    localparam int NODE_W = 4;
    localparam int RSVD_W = 2; // spare bits above the location, always sent as zero

    // low bit of every flit field, packed from bit 0 upward
    localparam int DIR_LO      = 0;
    localparam int XHOP_LO     = DIR_LO + DIR_W;
    localparam int YHOP_LO     = XHOP_LO + HOP_W;
    localparam int TSTEP_BIT   = YHOP_LO + HOP_W;   // set on the final timestep of an inference
    localparam int SPIKE_BIT   = TSTEP_BIT + 1;
    localparam int ACK_BIT     = SPIKE_BIT;         // an ack flit reuses the outspike position
    localparam int NODE_LO     = SPIKE_BIT + 1;
    localparam int RESIDUE_LO  = NODE_LO + NODE_W;
    localparam int CONV_LOC_LO = RESIDUE_LO + RESIDUE_W;
    localparam int RSVD_LO     = CONV_LOC_LO + CONV_LOC_W;

    // the full flit is every field above stacked together
    localparam int FLIT_W = RSVD_LO + RSVD_W;

    // output port of the mesh router that a flit leaves through
    typedef enum logic [DIR_W-1:0] {
        dir_east  = 2'd0,
        dir_north = 2'd1,
        dir_west  = 2'd2,
        dir_south = 2'd3
    } dir_t;

    // packetizer FSM
    // idle waits for a result, spike holds the data flit and ack holds the acknowledge flit
    typedef enum logic [1:0] {
        pkt_idle  = 2'd0,
        pkt_spike = 2'd1,
        pkt_ack   = 2'd2
    } pkt_state_t;

endpackage

//--- project.f
+incdir+tests
logic/snn_noc_pkg.sv
logic/neuron_result_if.sv
logic/flit_if.sv
logic/membrane_accumulator.sv
logic/packetizer.sv
logic/noc_output_queue.sv
logic/pe_output_stage.sv
tests/tb_pe_output_stage.sv

//--- tests/pe_output_model.svh
`ifndef PE_OUTPUT_MODEL_SVH
`define PE_OUTPUT_MODEL_SVH

// reference model of the output stage, included inside the testbench module
int                model_res [NUM_LOC]; // expected stored residue per location
logic [FLIT_W-1:0] exp_flits [$];       // flits in the order the network port must show them

// clamp a wide result into the signed residue range
function automatic int clamp_residue(input int value);
    int hi;
    int lo;
    hi = (1 << (RESIDUE_W - 1)) - 1;
    lo = -(1 << (RESIDUE_W - 1));
    if (value > hi) return hi;
    if (value < lo) return lo;
    return value;
endfunction

function automatic logic [FLIT_W-1:0] make_spike_flit(input int loc, input int res,
                                                      input bit spike, input bit ts);
    logic [FLIT_W-1:0] f;
    f = '0;
    f[DIR_LO +: DIR_W]               = TB_DIR_OUT;   // outbound route
    f[XHOP_LO +: HOP_W]              = TB_X_HOP_OUT;
    f[YHOP_LO +: HOP_W]              = TB_Y_HOP_OUT;
    f[TSTEP_BIT]                     = ts;
    f[SPIKE_BIT]                     = spike;
    f[NODE_LO +: NODE_W]             = TB_PE_NODE;
    f[RESIDUE_LO +: RESIDUE_W]       = RESIDUE_W'(res);
    f[CONV_LOC_LO +: CONV_LOC_W]     = CONV_LOC_W'(loc);
    return f;
endfunction

// ack carries only its route, the flag and the node, everything else stays zero
function automatic logic [FLIT_W-1:0] make_ack_flit();
    logic [FLIT_W-1:0] f;
    f = '0;
    f[DIR_LO +: DIR_W]   = TB_DIR_ACK;
    f[XHOP_LO +: HOP_W]  = TB_X_HOP_ACK;
    f[YHOP_LO +: HOP_W]  = TB_Y_HOP_ACK;
    f[ACK_BIT]           = 1'b1;
    f[NODE_LO +: NODE_W] = TB_PE_NODE;
    return f;
endfunction

// apply one finished group of beats and queue the flits it must produce
function automatic void model_group(input int loc, input int vals[$], input bit ts);
    int run;
    int pot;
    int new_res;
    bit spike;
    run = 0;
    foreach (vals[i]) run = clamp_residue(run + vals[i]);
    pot     = clamp_residue(model_res[loc] + run);
    spike   = (pot >= THRESHOLD);
    new_res = spike ? pot - THRESHOLD : pot; // a spike removes one threshold from the potential
    model_res[loc] = ts ? 0 : new_res;      // the final timestep leaves the location at rest
    exp_flits.push_back(make_spike_flit(loc, new_res, spike, ts));
    if (ts) exp_flits.push_back(make_ack_flit());
endfunction

`endif

//--- tests/tb_pe_output_stage.sv
`timescale 1ns/1ps

module tb_pe_output_stage import snn_noc_pkg::*; ();

    localparam int NUM_LOC     = 16;
    localparam int THRESHOLD   = 64;
    localparam int QUEUE_DEPTH = 4;

    // header values chosen apart from the RTL defaults so a dropped parameter shows up
    localparam logic [NODE_W-1:0] TB_PE_NODE   = 4'd9;
    localparam logic [HOP_W-1:0]  TB_X_HOP_OUT = 3'd3;
    localparam logic [HOP_W-1:0]  TB_Y_HOP_OUT = 3'd2;
    localparam dir_t              TB_DIR_OUT   = dir_north;
    localparam logic [HOP_W-1:0]  TB_X_HOP_ACK = 3'd5;
    localparam logic [HOP_W-1:0]  TB_Y_HOP_ACK = 3'd4;
    localparam dir_t              TB_DIR_ACK   = dir_south;

    localparam int NUM_RUNS    = 60;   // inference runs, each closing with a final timestep
    localparam int BEAT_LIMIT  = 200;  // cycles a beat may wait for psum_ready
    localparam int DRAIN_LIMIT = 2000; // cycles allowed for the queue to empty at the end

    logic                        clk;
    logic                        rst_n;
    logic                        psum_valid;
    logic                        psum_ready;
    logic signed [RESIDUE_W-1:0] psum;
    logic [CONV_LOC_W-1:0]       psum_loc;
    logic                        psum_last;
    logic                        psum_timestep;
    logic                        noc_valid;
    logic                        noc_ready;
    logic [FLIT_W-1:0]           noc_flit;

    int errors;
    int flits_seen;

    `include "pe_output_model.svh"

    pe_output_stage #(
        .NUM_LOC       (NUM_LOC),
        .THRESHOLD     (THRESHOLD),
        .QUEUE_DEPTH   (QUEUE_DEPTH),
        .PE_NODE       (TB_PE_NODE),
        .X_HOP_OUT     (TB_X_HOP_OUT),
        .Y_HOP_OUT     (TB_Y_HOP_OUT),
        .DIRECTION_OUT (TB_DIR_OUT),
        .X_HOP_ACK     (TB_X_HOP_ACK),
        .Y_HOP_ACK     (TB_Y_HOP_ACK),
        .DIRECTION_ACK (TB_DIR_ACK)
    ) u_pe_output_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .psum_valid    (psum_valid),
        .psum_ready    (psum_ready),
        .psum          (psum),
        .psum_loc      (psum_loc),
        .psum_last     (psum_last),
        .psum_timestep (psum_timestep),
        .noc_valid     (noc_valid),
        .noc_ready     (noc_ready),
        .noc_flit      (noc_flit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    task automatic stop_on_error(input string why);
        errors++;
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h",
                                    name, actual, expected));
        end
    endtask

    // called on a falling edge, returns on the falling edge after the beat was taken
    task automatic send_beat(input int loc, input int value, input bit last, input bit ts);
        int waited;
        psum_valid    = 1'b1;
        psum          = RESIDUE_W'(value);
        psum_loc      = CONV_LOC_W'(loc);
        psum_last     = last;
        psum_timestep = ts;
        waited        = 0;
        while (!psum_ready) begin // ready only moves on a rising edge, so mid-cycle is safe
            @(negedge clk);
            waited++;
            if (waited > BEAT_LIMIT) stop_on_error("psum_ready stayed low and no beat was taken");
        end
        @(negedge clk);
    endtask

    task automatic send_group(input int loc, input bit ts);
        int vals[$];
        int beats;
        beats = $urandom_range(1, 4);
        for (int b = 0; b < beats; b++) begin
            vals.push_back(int'($urandom_range(0, 90)) - 30); // mostly excitatory, some inhibition
        end
        for (int b = 0; b < beats; b++) begin
            send_beat(loc, vals[b], b == beats - 1, ts);
        end
        psum_valid = 1'b0;
        psum_last  = 1'b0;
        model_group(loc, vals, ts); // the last beat is in, its flits are at least cycles away
    endtask

    // network side with random back-pressure, every accepted flit is compared in order
    initial begin
        logic [FLIT_W-1:0] expected;
        noc_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                noc_ready = 1'b0;
            end else begin
                noc_ready = ($urandom_range(0, 99) >= 30); // low about 30% of the time
                // valid and flit are registered, so this pair is what the next rising edge takes
                if (noc_valid && noc_ready) begin
                    if (exp_flits.size() == 0) begin
                        stop_on_error("a flit left the network port when none was expected");
                    end else begin
                        expected = exp_flits.pop_front();
                        check_value("noc_flit", noc_flit, expected);
                        flits_seen++;
                    end
                end
            end
        end
    end

    initial begin
        int run_len;
        int loc;
        int waited;
        void'($urandom(93070));
        errors        = 0;
        flits_seen    = 0;
        rst_n         = 1'b0;
        psum_valid    = 1'b0;
        psum          = '0;
        psum_loc      = '0;
        psum_last     = 1'b0;
        psum_timestep = 1'b0;
        foreach (model_res[i]) model_res[i] = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("noc_valid", noc_valid, 64'd0);
        check_value("psum_ready", psum_ready, 64'd1);

        for (int r = 0; r < NUM_RUNS; r++) begin
            run_len = $urandom_range(1, 6); // timesteps in this inference run
            for (int g = 0; g < run_len; g++) begin
                loc = $urandom_range(0, NUM_LOC - 1);
                send_group(loc, g == run_len - 1);
                repeat ($urandom_range(0, 3)) @(negedge clk);
            end
        end

        waited = 0;
        while (exp_flits.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) stop_on_error("expected flits never reached the network port");
        end
        repeat (20) @(negedge clk); // anything extra would show up on the port here
        check_value("noc_valid", noc_valid, 64'd0);
        $display("checked %0d flits", flits_seen);

        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
